// File: sim.f
+incdir+.
v06c_pkg.sv
cycle_oneshot.sv
clock_enables.sv
cpu_bus_control.sv
io_port_decoder.sv
palette_writer.sv
retrace_irq.sv
v06c_glue_top.sv
v06c_glue_assertions.sv
tb_v06c_glue.sv

// File: Makefile
SRCS := $(shell grep -v '^+' sim.f)

.PHONY: all run clean

all: run

obj_dir/Vtb_v06c_glue: sim.f $(SRCS) tb_v06c_tasks.svh
	verilator --binary --timing --assert -f sim.f --top-module tb_v06c_glue -Mdir obj_dir

run: obj_dir/Vtb_v06c_glue
	./obj_dir/Vtb_v06c_glue > sim.log 2>&1; cat sim.log
	! grep -q '>>> FAIL' sim.log
	grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_v06c_tasks.svh
////////////////////
// Directed tests for the CPU glue testbench
////////////////////

task automatic abort_run(input string msg);
	$display("%s", msg);
	$display(">>> FAIL");
	$fatal(1, "Simulation stopped");
endtask

task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
	if (got !== exp)
		abort_run($sformatf("Error: %s = %h, expected %h", name, got, exp));
endtask

// Drive point, 2 ns after the rising edge
task automatic next_cycle;
	@(posedge clk24);
	#2;
endtask

task automatic wait_cpu_slot(input bit avoid_ws);
	int n = 0;
	while (!o_cpu_ce || (avoid_ws && o_ce.ws_window)) begin
		next_cycle;
		n++;
		if (n > 64)
			abort_run("No CPU clock enable arrived");
	end
endtask

task automatic run_sync(input logic [7:0] st);
	wait_cpu_slot(1'b1);
	i_sync   = 1'b1;
	i_cpu_do = st;
	next_cycle;
	i_sync   = 1'b0;
endtask

task automatic set_mode(input clock_mode_e m);
	i_clk_mode = m;
	repeat (2) next_cycle;
endtask

task automatic count_cpu_ce(input int cycles, output int n);
	n = 0;
	repeat (cycles) begin
		if (o_cpu_ce) begin
			n++;
			if (i_clk_mode == WARP)
				check("o_ce.video_slice", 8'(o_ce.video_slice), 8'h00);
		end
		next_cycle;
	end
endtask

// Enable pulse counts over one phase period
task automatic enable_pulse_counts;
	int n12 = 0;
	int n6 = 0;
	int n3 = 0;
	int n_vid = 0;
	int n_ws = 0;
	repeat (32) begin
		if (o_ce.ce12)
			n12++;
		if (o_ce.ce6) begin
			n6++;
			check("o_ce.ce12", 8'(o_ce.ce12), 8'h01);   // ce6 sits on a ce12 pulse
		end
		if (o_ce.ce3) begin
			n3++;
			check("o_ce.ce6", 8'(o_ce.ce6), 8'h01);
		end
		if (o_ce.video_slice)
			n_vid++;
		if (o_ce.ws_window)
			n_ws++;
		next_cycle;
	end
	check("o_ce.ce12 count", 8'(n12), 8'd16);
	check("o_ce.ce6 count", 8'(n6), 8'd8);
	check("o_ce.ce3 count", 8'(n3), 8'd4);
	check("o_ce.video_slice count", 8'(n_vid), 8'd16);
	check("o_ce.ws_window count", 8'(n_ws), 8'd4);
endtask

////////////////////
// Clock modes

task automatic clock_mode_rates;
	int n;
	set_mode(NORMAL);
	enable_pulse_counts;
	count_cpu_ce(256, n);
	check("o_cpu_ce count normal", 8'(n), 8'd32);
	set_mode(WARP);
	count_cpu_ce(256, n);
	check("o_cpu_ce count warp", 8'(n), 8'd64);
	set_mode(SLOW);
	count_cpu_ce(8192, n);
	check("o_cpu_ce count slow", 8'(n), 8'd1);
	set_mode(SINGLE);
	count_cpu_ce(16, n);
	check("o_cpu_ce count single", 8'(n), 8'd0);
	repeat (2) begin
		i_key_tap = 1'b1;
		next_cycle;
		check("o_cpu_ce", 8'(o_cpu_ce), 8'h00);
		next_cycle;
		check("o_cpu_ce", 8'(o_cpu_ce), 8'h00);
		next_cycle;
		check("o_cpu_ce", 8'(o_cpu_ce), 8'h01);     // Third cycle after the tap
		repeat (4) begin
			next_cycle;
			check("o_cpu_ce", 8'(o_cpu_ce), 8'h00);
		end
		i_key_tap = 1'b0;
		repeat (4) next_cycle;
	end
	set_mode(NORMAL);
endtask

////////////////////
// Wait states

task automatic wait_state_timing;
	int n = 0;
	run_sync(8'hA2);                                 // Opcode fetch from memory
	while (!o_ce.ws_window) begin
		check("o_ready", 8'(o_ready), 8'h00);
		next_cycle;
		n++;
		if (n > 32)
			abort_run("The wait state window never came");
	end
	next_cycle;
	check("o_ready", 8'(o_ready), 8'h01);
	run_sync(8'h10);                                 // I/O write, wo_n low
	repeat (16) begin
		check("o_ready", 8'(o_ready), 8'h01);
		next_cycle;
	end
	set_mode(WARP);
	run_sync(8'hA2);
	repeat (16) begin
		check("o_ready", 8'(o_ready), 8'h01);
		next_cycle;
	end
	set_mode(NORMAL);
endtask

////////////////////
// Port decode

task automatic write_port(input logic [7:0] port, input logic [7:0] data);
	i_port_addr = port;
	run_sync(8'h10);
	wait_cpu_slot(1'b0);
	i_wr_n   = 1'b0;
	i_cpu_do = data;
	next_cycle;
	i_wr_n   = 1'b1;
endtask

function automatic bit port_selected(input logic [7:0] p);
	if (p[7:5] != 3'b000)
		return 1'b0;
	if (p[4:2] == 3'd5)
		return ~p[1];                                // AY only at 14, 15
	if (p[4:2] == 3'd4)
		return p == 8'h10;
	return 1'b1;
endfunction

function automatic logic [7:0] expected_read(input logic [7:0] p);
	if (!port_selected(p))
		return 8'hFF;
	case (p[4:2])
		3'd0:    return i_periph_rdata.ppi;
		3'd1:    return 8'h00;
		3'd2:    return i_periph_rdata.pit;
		3'd5:    return i_periph_rdata.ay;
		3'd6:    return i_periph_rdata.fdc;
		3'd7:    return i_periph_rdata.fdc;
		default: return 8'hFF;
	endcase
endfunction

task automatic port_write_decode;
	logic [7:0] ports [9];
	logic [7:0] bad [3];
	ports = '{8'h00, 8'h05, 8'h0A, 8'h0F, 8'h10, 8'h14, 8'h15, 8'h1B, 8'h1C};
	bad   = '{8'h11, 8'h16, 8'h20};
	foreach (ports[i]) begin
		write_port(ports[i], ports[i] ^ 8'h5C);
		check("o_periph_req.wr", 8'(o_periph_req.wr), 8'h01);
		check("o_periph_req.dev", 8'(o_periph_req.dev), {5'd0, ports[i][4:2]});
		check("o_periph_req.reg_idx", 8'(o_periph_req.reg_idx), {6'd0, ~ports[i][1:0]});
		check("o_periph_req.wdata", o_periph_req.wdata, ports[i] ^ 8'h5C);
		next_cycle;
		check("o_periph_req.wr", 8'(o_periph_req.wr), 8'h00);
	end
	foreach (bad[i]) begin
		write_port(bad[i], 8'hA5);
		check("o_periph_req.wr", 8'(o_periph_req.wr), 8'h00);
		next_cycle;
		check("o_periph_req.wr", 8'(o_periph_req.wr), 8'h00);
	end
endtask

task automatic port_read_mux;
	logic [7:0] ports [12];
	ports = '{8'h01, 8'h06, 8'h09, 8'h0D, 8'h10, 8'h11,
	          8'h14, 8'h16, 8'h1A, 8'h1F, 8'h20, 8'hFF};
	foreach (ports[i]) begin
		i_port_addr = ports[i];
		run_sync(8'h42);
		check("o_cpu_di", o_cpu_di, expected_read(ports[i]));
		next_cycle;
		check("o_periph_req.rd", 8'(o_periph_req.rd), 8'(port_selected(ports[i])));
	end
endtask

////////////////////
// Data-in, palette, interrupt

task automatic data_in_select;
	int n = 0;
	i_mem_rdata = 8'h5A;
	run_sync(8'h23);                                 // Interrupt acknowledge
	check("o_cpu_di", o_cpu_di, 8'hFF);
	i_port_addr = 8'h09;
	run_sync(8'h42);
	check("o_cpu_di", o_cpu_di, i_periph_rdata.pit);
	run_sync(8'h82);
	check("o_cpu_di", o_cpu_di, 8'h5A);
	while (!o_ready) begin
		next_cycle;
		n++;
		if (n > 32)
			abort_run("READY stayed low after a memory read");
	end
endtask

task automatic palette_write_window;
	int n = 0;
	write_port(8'h0C, 8'hC3);
	while (!o_palette.wren) begin
		next_cycle;
		n++;
		if (n > 18)
			abort_run("Palette write enable did not rise within 18 cycles");
	end
	check("o_palette.value", o_palette.value, 8'hC3);
	n = 0;
	while (o_palette.wren) begin
		next_cycle;
		n++;
		if (n > 16)
			abort_run("Palette write enable stayed high too long");
	end
	if (n < 12)
		abort_run($sformatf("Palette write enable high for only %0d cycles", n));
endtask

task automatic retrace_interrupt;
	int n_ce = 0;
	int cycles = 0;
	i_inte    = 1'b1;
	i_retrace = 1'b1;
	while (!o_int) begin
		if (o_cpu_ce)
			n_ce++;
		next_cycle;
		cycles++;
		if (cycles > 400)
			abort_run("The retrace interrupt never came");
	end
	if (n_ce < 28 || n_ce > 29)
		abort_run($sformatf("Interrupt came after %0d CPU enables", n_ce));
	run_sync(8'h23);
	next_cycle;
	check("o_int", 8'(o_int), 8'h00);
	i_retrace = 1'b0;
	run_sync(8'h42);                                 // Drop int_ack from the status latch
	repeat (1700) next_cycle;
	i_inte    = 1'b0;
	i_retrace = 1'b1;
	repeat (2000) begin
		check("o_int", 8'(o_int), 8'h00);
		next_cycle;
	end
	i_retrace = 1'b0;
endtask

// File: tb_v06c_glue.sv
////////////////////
// Vector-06C CPU glue testbench
// Clock, reset, peripheral model, watchdog and the
// directed test sequence
////////////////////

`timescale 1ns/10ps

module tb_v06c_glue;
	import v06c_pkg::*;

	localparam int CLK_PERIOD  = 40;
	localparam int MODE_CYCLES = 2 * 256 + 8192 + 200;   // Normal, warp, slow, single tap
	localparam int BUS_CYCLES  = 3000;                   // Waits, ports, data-in, palette
	localparam int IRQ_CYCLES  = 400 + 1700 + 2100;
	localparam int WATCHDOG_CYCLES = 2 * (MODE_CYCLES + BUS_CYCLES + IRQ_CYCLES);

	logic          clk24;
	logic          RESET_n;
	clock_mode_e   i_clk_mode;
	logic          i_key_tap;
	logic          i_sync;
	logic          i_wr_n;
	logic [7:0]    i_cpu_do;
	logic [7:0]    i_port_addr;
	logic [7:0]    i_mem_rdata;
	periph_rdata_t i_periph_rdata;
	logic          i_retrace;
	logic          i_inte;
	logic          o_cpu_ce;
	logic          o_ready;
	logic          o_int;
	logic [7:0]    o_cpu_di;
	periph_req_t   o_periph_req;
	palette_t      o_palette;
	ce_t           o_ce;

	int seed;

	v06c_glue_top UUT (.*);

	`include "tb_v06c_tasks.svh"

	initial begin
		clk24 = 1'b0;
		forever #(CLK_PERIOD / 2) clk24 = ~clk24;
	end

	// Watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("Timeout: the test sequence did not finish in time");
	end

	initial begin
		seed        = 76;
		RESET_n     = 1'b0;
		i_clk_mode  = NORMAL;
		i_key_tap   = 1'b0;
		i_sync      = 1'b0;
		i_wr_n      = 1'b1;
		i_cpu_do    = 8'h00;
		i_port_addr = 8'h00;
		i_mem_rdata = 8'h00;
		i_retrace   = 1'b0;
		i_inte      = 1'b0;
		// Peripheral model holds fixed bytes
		i_periph_rdata.ppi = 8'($random(seed));
		i_periph_rdata.pit = 8'($random(seed));
		i_periph_rdata.ay  = 8'($random(seed));
		i_periph_rdata.fdc = 8'($random(seed));

		repeat (4) @(posedge clk24);
		#2 RESET_n = 1'b1;
		next_cycle;

		clock_mode_rates;
		wait_state_timing;
		port_write_decode;
		port_read_mux;
		data_in_select;
		palette_write_window;
		retrace_interrupt;

		if (UUT.u_assertions.fail_count == 0) begin
			$display(">>> PASS");
			$finish;
		end else
			abort_run("A bound assertion failed during the run");
	end

endmodule

// File: v06c_glue_assertions.sv
////////////////////
// Bound checks on the CPU glue top level
// Strobe exclusion, interrupt enable, READY release
////////////////////

`timescale 1ns/10ps

module v06c_glue_assertions (
	input logic                  clk24,
	input logic                  RESET_n,
	input logic                  i_inte,
	input logic                  o_int,
	input logic                  o_ready,
	input v06c_pkg::periph_req_t o_periph_req
);

	int fail_count = 0;    // Failed assertions, read from the testbench top

	// Never read and write at once
	assert property (@(posedge clk24) disable iff (!RESET_n)
		!(o_periph_req.wr && o_periph_req.rd))
		else begin
			fail_count++;
			$error("wr and rd high together");
		end

	assert property (@(posedge clk24) disable iff (!RESET_n)
		$rose(o_int) |-> $past(i_inte))
		else begin
			fail_count++;
			$error("o_int rose with interrupts disabled");
		end

	// Wait states end within one phase period
	assert property (@(posedge clk24) disable iff (!RESET_n)
		!o_ready |-> ##[1:32] o_ready)
		else begin
			fail_count++;
			$error("o_ready held low too long");
		end

endmodule

bind v06c_glue_top v06c_glue_assertions u_assertions (
	.clk24        (clk24),
	.RESET_n      (RESET_n),
	.i_inte       (i_inte),
	.o_int        (o_int),
	.o_ready      (o_ready),
	.o_periph_req (o_periph_req)
);

// File: v06c_glue_top.sv
////////////////////
// Vector-06C CPU glue top level
// Clock enables, bus control, port decode, palette
// write timing and the retrace interrupt
////////////////////

`timescale 1ns/10ps

module v06c_glue_top (
	input  logic                    clk24,
	input  logic                    RESET_n,
	input  v06c_pkg::clock_mode_e   i_clk_mode,
	input  logic                    i_key_tap,
	input  logic                    i_sync,
	input  logic                    i_wr_n,
	input  logic [7:0]              i_cpu_do,
	input  logic [7:0]              i_port_addr,
	input  logic [7:0]              i_mem_rdata,
	input  v06c_pkg::periph_rdata_t i_periph_rdata,
	input  logic                    i_retrace,
	input  logic                    i_inte,
	output logic                    o_cpu_ce,
	output logic                    o_ready,
	output logic                    o_int,
	output logic [7:0]              o_cpu_di,
	output v06c_pkg::periph_req_t   o_periph_req,
	output v06c_pkg::palette_t      o_palette,
	output v06c_pkg::ce_t           o_ce
);
	import v06c_pkg::*;

	cpu_status_t status;
	logic [7:0]  io_rdata;

	clock_enables u_clocks (
		.clk24      (clk24),
		.RESET_n    (RESET_n),
		.i_clk_mode (i_clk_mode),
		.i_key_tap  (i_key_tap),
		.o_ce       (o_ce),
		.o_cpu_ce   (o_cpu_ce)
	);

	cpu_bus_control u_bus (
		.clk24       (clk24),
		.RESET_n     (RESET_n),
		.i_ce        (o_ce),
		.i_cpu_ce    (o_cpu_ce),
		.i_warp      (i_clk_mode == WARP),   // No wait states in warp
		.i_sync      (i_sync),
		.i_cpu_do    (i_cpu_do),
		.i_mem_rdata (i_mem_rdata),
		.i_io_rdata  (io_rdata),
		.o_status    (status),
		.o_ready     (o_ready),
		.o_cpu_di    (o_cpu_di)
	);

	io_port_decoder u_ports (
		.clk24          (clk24),
		.RESET_n        (RESET_n),
		.i_cpu_ce       (o_cpu_ce),
		.i_wr_n         (i_wr_n),
		.i_status       (status),
		.i_cpu_do       (i_cpu_do),
		.i_port_addr    (i_port_addr),
		.i_periph_rdata (i_periph_rdata),
		.o_periph_req   (o_periph_req),
		.o_io_rdata     (io_rdata)
	);

	palette_writer u_palette (
		.clk24        (clk24),
		.RESET_n      (RESET_n),
		.i_ce         (o_ce),
		.i_periph_req (o_periph_req),
		.o_palette    (o_palette)
	);

	retrace_irq u_irq (
		.clk24     (clk24),
		.RESET_n   (RESET_n),
		.i_cpu_ce  (o_cpu_ce),
		.i_retrace (i_retrace),
		.i_inte    (i_inte),
		.i_status  (status),
		.o_int     (o_int)
	);

endmodule

// File: retrace_irq.sv
////////////////////
// Retrace interrupt
// Delay after retrace, then the interrupt tick, and the
// request flip-flop held until the CPU acknowledges
////////////////////

`timescale 1ns/10ps

module retrace_irq (
	input  logic                  clk24,
	input  logic                  RESET_n,
	input  logic                  i_cpu_ce,
	input  logic                  i_retrace,
	input  logic                  i_inte,
	input  v06c_pkg::cpu_status_t i_status,
	output logic                  o_int
);
	import v06c_pkg::*;

	logic int_delay, delay_q;
	logic int_tick, tick_q;
	logic int_q;

	cycle_oneshot #(.TICKS(IRQ_DELAY_TICKS)) u_delay (
		.clk24     (clk24),
		.RESET_n   (RESET_n),
		.i_cpu_ce  (i_cpu_ce),
		.i_trigger (i_retrace),
		.o_pulse   (int_delay)
	);

	// Fires at the end of the delay
	cycle_oneshot #(.TICKS(IRQ_TICK_LEN)) u_tick (
		.clk24     (clk24),
		.RESET_n   (RESET_n),
		.i_cpu_ce  (i_cpu_ce),
		.i_trigger (delay_q & ~int_delay),
		.o_pulse   (int_tick)
	);

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			delay_q <= 1'b0;
			tick_q  <= 1'b0;
			int_q   <= 1'b0;
		end else begin
			delay_q <= int_delay;
			tick_q  <= int_tick;
			if (i_status.int_ack)
				int_q <= 1'b0;          // Ack wins
			else if (int_tick && !tick_q && i_inte)
				int_q <= 1'b1;
		end
	end

	assign o_int = int_q;

endmodule

// File: palette_writer.sv
////////////////////
// Palette writer
// Mimics the async palette RAM write window of the
// original board: hold for 3 pixel clocks, then delay
////////////////////

`timescale 1ns/10ps

module palette_writer (
	input  logic                  clk24,
	input  logic                  RESET_n,
	input  v06c_pkg::ce_t         i_ce,
	input  v06c_pkg::periph_req_t i_periph_req,
	output v06c_pkg::palette_t    o_palette
);
	import v06c_pkg::*;

	logic [7:0]                          value_q;
	logic [$clog2(PAL_HOLD_CE6 + 1)-1:0] hold_cnt;
	logic [PAL_DELAY_CE12-1:0]           wren_dly;
	logic                                pal_wr;

	assign pal_wr = i_periph_req.wr & (i_periph_req.dev == DEV_INTERNAL);

	always_ff @(posedge clk24) begin
		if (pal_wr)
			value_q <= i_periph_req.wdata;
	end

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			hold_cnt <= '0;
			wren_dly <= '0;
		end else begin
			if (pal_wr)
				hold_cnt <= $bits(hold_cnt)'(PAL_HOLD_CE6);
			else if (i_ce.ce6 && hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
			if (i_ce.ce12)
				wren_dly <= {wren_dly[PAL_DELAY_CE12-2:0], hold_cnt != '0};
		end
	end

	assign o_palette.value = value_q;
	assign o_palette.wren  = wren_dly[PAL_DELAY_CE12-1];

endmodule

// File: io_port_decoder.sv
////////////////////
// I/O port decoder
// Latches the port address, selects a device, qualifies
// the strobes and picks the peripheral read byte
////////////////////

`timescale 1ns/10ps

module io_port_decoder (
	input  logic                    clk24,
	input  logic                    RESET_n,
	input  logic                    i_cpu_ce,
	input  logic                    i_wr_n,
	input  v06c_pkg::cpu_status_t   i_status,
	input  logic [7:0]              i_cpu_do,
	input  logic [7:0]              i_port_addr,
	input  v06c_pkg::periph_rdata_t i_periph_rdata,
	output v06c_pkg::periph_req_t   o_periph_req,
	output logic [7:0]              o_io_rdata
);
	import v06c_pkg::*;

	logic [7:0]  port_q;
	io_dev_e     dev;
	logic        dev_sel;
	logic        rd_sel;
	logic        ppi_rd, pu_rd, pit_rd, ay_rd, fdc_rd;
	periph_req_t req_q;

	// Ports 000xxxYY
	assign dev = io_dev_e'(port_q[4:2]);

	always_comb begin
		dev_sel = (port_q[7:5] == 3'b000);
		if (dev == DEV_AY)
			dev_sel = dev_sel & ~port_q[1];          // Only 14 and 15
		else if (dev == DEV_RAMDISK)
			dev_sel = (port_q == PORT_RAMDISK);
	end

	assign rd_sel = i_status.io_read & dev_sel;
	assign ppi_rd = rd_sel & (dev == DEV_PPI);
	assign pu_rd  = rd_sel & (dev == DEV_PU);
	assign pit_rd = rd_sel & (dev == DEV_PIT);
	assign ay_rd  = rd_sel & (dev == DEV_AY);
	assign fdc_rd = rd_sel & ((dev == DEV_FDC0) | (dev == DEV_FDC1));

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			port_q <= '0;
			req_q  <= '0;
		end else begin
			if (i_cpu_ce)
				port_q <= i_port_addr;
			req_q.dev     <= dev;
			req_q.reg_idx <= ~port_q[1:0];  // Inverted as on the board
			req_q.wdata   <= i_cpu_do;
			req_q.wr      <= i_cpu_ce & ~i_wr_n & i_status.io_write & dev_sel;
			req_q.rd      <= rd_sel;
		end
	end

	assign o_periph_req = req_q;

	////////////////////
	// Read byte select

	always_comb begin
		case ({ppi_rd, pu_rd, pit_rd, ay_rd, fdc_rd})
			5'b10000: o_io_rdata = i_periph_rdata.ppi;
			5'b01000: o_io_rdata = 8'h00;    // No parallel unit fitted
			5'b00100: o_io_rdata = i_periph_rdata.pit;
			5'b00010: o_io_rdata = i_periph_rdata.ay;
			5'b00001: o_io_rdata = i_periph_rdata.fdc;
			default:  o_io_rdata = 8'hFF;
		endcase
	end

endmodule

// File: cpu_bus_control.sv
////////////////////
// CPU bus control
// 8080 status latch, READY wait states and data-in select
////////////////////

`timescale 1ns/10ps

module cpu_bus_control (
	input  logic                  clk24,
	input  logic                  RESET_n,
	input  v06c_pkg::ce_t         i_ce,
	input  logic                  i_cpu_ce,
	input  logic                  i_warp,
	input  logic                  i_sync,
	input  v06c_pkg::cpu_byte_u   i_cpu_do,
	input  logic [7:0]            i_mem_rdata,
	input  logic [7:0]            i_io_rdata,
	output v06c_pkg::cpu_status_t o_status,
	output logic                  o_ready,
	output logic [7:0]            o_cpu_di
);
	import v06c_pkg::*;

	cpu_status_t status_q;
	logic        ready_q;
	logic        mem_req;

	// CPU wants memory, not I/O
	assign mem_req = (i_cpu_do.status.mem_read | ~i_cpu_do.status.wo_n)
		& ~i_cpu_do.status.io_read & ~i_cpu_do.status.io_write;

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			status_q <= '0;
			ready_q  <= 1'b1;
		end else begin
			if (i_cpu_ce && i_sync)
				status_q <= i_cpu_do.status;

			// Release in the CPU slice, which beats a new wait request
			if (i_ce.ws_window)
				ready_q <= 1'b1;
			else if (i_cpu_ce && i_sync && !i_warp && mem_req)
				ready_q <= 1'b0;  // Memory cycle outside CPU slice
		end
	end

	always_comb begin
		if (status_q.int_ack)
			o_cpu_di = 8'hFF;     // RST 7 on the bus
		else if (status_q.io_read)
			o_cpu_di = i_io_rdata;
		else
			o_cpu_di = i_mem_rdata;
	end

	assign o_status = status_q;
	assign o_ready  = ready_q;

endmodule

// File: clock_enables.sv
////////////////////
// Clock enables
// Phase counter, ce12/ce6/ce3 pulses, wait state window
// and the CPU enable for the four speed modes
////////////////////

`timescale 1ns/10ps

module clock_enables (
	input  logic                  clk24,
	input  logic                  RESET_n,
	input  v06c_pkg::clock_mode_e i_clk_mode,
	input  logic                  i_key_tap,
	output v06c_pkg::ce_t         o_ce,
	output logic                  o_cpu_ce
);
	import v06c_pkg::*;

	logic [PHASE_BITS-1:0]    phase;
	logic [SLOW_DIV_BITS-1:0] slow_div;
	clock_mode_e              mode_q;
	logic [1:0]               tap_sync;
	logic                     tap_q;
	logic                     tap_pulse;

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			phase     <= '0;
			slow_div  <= '0;
			mode_q    <= NORMAL;
			tap_sync  <= 2'b00;
			tap_q     <= 1'b0;
			tap_pulse <= 1'b0;
		end else begin
			phase  <= phase + 1'b1;
			mode_q <= i_clk_mode;
			if (o_ce.ce3)
				slow_div <= slow_div + 1'b1;

			// Key tap synchronizer and rising edge
			tap_sync  <= {tap_sync[0], i_key_tap};
			tap_q     <= tap_sync[1];
			tap_pulse <= tap_sync[1] & ~tap_q;
		end
	end

	////////////////////
	// Enables from phase

	always_comb begin
		o_ce.ce12        = phase[0];
		o_ce.ce6         = &phase[1:0];
		o_ce.ce3         = &phase[2:0];
		o_ce.video_slice = phase[3];
		o_ce.ws_window   = (phase[4:2] == WS_WINDOW_PHASE);
	end

	// CPU enable per speed mode
	always_comb begin
		case (mode_q)
			WARP:    o_cpu_ce = o_ce.ce12 & ~o_ce.video_slice;  // Steal only CPU slices
			SLOW:    o_cpu_ce = o_ce.ce3 & (slow_div == '0);
			SINGLE:  o_cpu_ce = tap_pulse;
			default: o_cpu_ce = o_ce.ce3;
		endcase
	end

endmodule

// File: cycle_oneshot.sv
////////////////////
// One-shot counted in CPU clock enables
////////////////////

`timescale 1ns/10ps

module cycle_oneshot #(
	parameter int TICKS = 28
) (
	input  logic clk24,
	input  logic RESET_n,
	input  logic i_cpu_ce,
	input  logic i_trigger,
	output logic o_pulse
);
	logic [$clog2(TICKS + 1)-1:0] cnt;
	logic                         trig_q;

	always_ff @(posedge clk24) begin
		if (!RESET_n) begin
			cnt    <= '0;
			trig_q <= 1'b0;
		end else begin
			trig_q <= i_trigger;
			if (i_trigger && !trig_q)
				cnt <= $bits(cnt)'(TICKS);   // Retrigger restarts the count
			else if (i_cpu_ce && cnt != '0)
				cnt <= cnt - 1'b1;
		end
	end

	assign o_pulse = (cnt != '0);

endmodule

// File: v06c_pkg.sv
////////////////////
// Vector-06C CPU glue shared definitions
// Timing constants, speed modes, device codes and the
// structs that carry enables, requests and read data
////////////////////

package v06c_pkg;

	////////////////////
	// Constants

	localparam int PHASE_BITS      = 5;      // Free-running 24 MHz phase
	localparam int SLOW_DIV_BITS   = 10;     // Slow mode divider, in ce3 ticks
	localparam int IRQ_DELAY_TICKS = 28;     // Retrace to interrupt tick
	localparam int IRQ_TICK_LEN    = 191;
	localparam int PAL_HOLD_CE6    = 3;      // Palette WR held for 3 pixel clocks
	localparam int PAL_DELAY_CE12  = 8;
	localparam logic [2:0] WS_WINDOW_PHASE = 3'd5;  // CPU memory slice
	localparam logic [7:0] PORT_RAMDISK    = 8'h10;

	////////////////////
	// Types

	typedef enum logic [1:0] {
		NORMAL = 2'b00,
		WARP   = 2'b01,    // 6 MHz, no wait states
		SLOW   = 2'b10,
		SINGLE = 2'b11     // Key tap clock
	} clock_mode_e;

	// Port bits 4:2
	typedef enum logic [2:0] {
		DEV_PPI      = 3'd0,
		DEV_PU       = 3'd1,
		DEV_PIT      = 3'd2,
		DEV_INTERNAL = 3'd3,
		DEV_RAMDISK  = 3'd4,
		DEV_AY       = 3'd5,
		DEV_FDC0     = 3'd6,
		DEV_FDC1     = 3'd7
	} io_dev_e;

	typedef struct packed {
		logic ce12;
		logic ce6;
		logic ce3;
		logic video_slice;    // Video owns the memory bus
		logic ws_window;
	} ce_t;

	// 8080 status word as put out on D7..D0 during SYNC
	typedef struct packed {
		logic mem_read;
		logic io_read;
		logic m1;
		logic io_write;
		logic halt_ack;
		logic stack;
		logic wo_n;
		logic int_ack;
	} cpu_status_t;

	typedef union packed {
		cpu_status_t status;
		logic [7:0]  data;
	} cpu_byte_u;

	typedef struct packed {
		io_dev_e    dev;
		logic [1:0] reg_idx;
		logic [7:0] wdata;
		logic       wr;
		logic       rd;
	} periph_req_t;

	typedef struct packed {
		logic [7:0] ppi;
		logic [7:0] pit;
		logic [7:0] ay;
		logic [7:0] fdc;
	} periph_rdata_t;

	typedef struct packed {
		logic [7:0] value;
		logic       wren;
	} palette_t;

endpackage
